//--- all.f
daq_pkg.sv
spi_reg_receiver.sv
daq_config_regs.sv
channel_scanner.sv
adc_sequencer.sv
sample_fifo.sv
serial_framer.sv
daq_top.sv
daq_props.sv
tb_daq_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_daq_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_daq_top.sv
`timescale 1ns/1ps

module tb_daq_top
    import daq_pkg::*;
();

    // Whole run is a few thousand cycles, this leaves a wide margin
    localparam int max_cycles   = 200000;
    localparam int quiet_cycles = 400;
    localparam int stop_window  = 100;
    localparam int rx_batch     = 24;

    logic                  clk;
    logic                  rst_n;
    logic                  spi_sclk;
    logic                  spi_mosi;
    logic                  spi_cs_n;
    logic                  adc_conv_done;
    logic                  adc_busy;
    logic [adc_width-1:0]  adc_data;
    logic                  adc_start_conv;
    logic [chan_width-1:0] adc_channel_sel;
    logic                  serial_data;
    logic                  serial_valid;

    integer                  seed = 32'h7f78fca3;
    int                      cycle_count = 0;
    int                      frame_end_cycle = 0;
    int                      rx_count = 0;
    int                      rx_bits = 0;
    logic [15:0]             rx_shift;
    logic                    fast_adc = 1'b0;
    logic [num_channels-1:0] model_mask = chan_en_default;
    logic [chan_width-1:0]   model_ptr = '0;
    sample_word_t            exp_q[$];

    daq_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .spi_sclk        (spi_sclk),
        .spi_mosi        (spi_mosi),
        .spi_cs_n        (spi_cs_n),
        .adc_conv_done   (adc_conv_done),
        .adc_busy        (adc_busy),
        .adc_data        (adc_data),
        .adc_start_conv  (adc_start_conv),
        .adc_channel_sel (adc_channel_sel),
        .serial_data     (serial_data),
        .serial_valid    (serial_valid)
    );

    always #2 clk = ~clk;
    always #10 spi_sclk = ~spi_sclk;

    // ====================
    // Helpers
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [15:0] reg_byte_addr(input logic [4:0] idx);
        return {9'd0, idx, 2'b00};
    endfunction

    // First enabled channel at or after the pointer, wrapping
    function automatic logic [chan_width-1:0] next_enabled(
        input logic [num_channels-1:0] mask,
        input logic [chan_width-1:0]   from
    );
        logic [chan_width-1:0] c;
        logic [chan_width-1:0] hit;
        logic                  found;
        c     = from;
        hit   = from;
        found = 1'b0;
        for (int i = 0; i < num_channels; i++) begin
            if (!found && mask[c]) begin
                hit   = c;
                found = 1'b1;
            end
            c = c + 1'b1;
        end
        return hit;
    endfunction

    // Command byte, two address bytes, four data bytes, MSB first
    task automatic spi_write(input logic [15:0] addr, input logic [31:0] data);
        logic [55:0] frame;
        frame = {8'h02, addr, data};
        @(posedge spi_sclk);
        spi_cs_n <= 1'b0;
        spi_mosi <= frame[55];
        for (int i = 54; i >= 0; i--) begin
            @(posedge spi_sclk);
            spi_mosi <= frame[i];
        end
        @(posedge spi_sclk);
        spi_cs_n <= 1'b1;
        spi_mosi <= 1'b0;
        frame_end_cycle = cycle_count;
        // Wait for the strobe in the clk domain, then for the register
        @(negedge clk);
        while (!i_dut.reg_wr) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // No start may follow the disabling frame by more than the window
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < quiet_cycles) begin
            @(negedge clk);
            if (adc_start_conv) begin
                quiet = 0;
                if (cycle_count - frame_end_cycle > stop_window) begin
                    check(32'(adc_start_conv), 32'd0, "conversion started while disabled");
                end
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic wait_rx(input int target);
        while (rx_count < target) begin
            @(negedge clk);
        end
    endtask

    // ====================
    // Timeout
    // ====================
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            abort_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    // ====================
    // ADC model
    // ====================
    always begin : adc_model
        logic [chan_width-1:0] exp_chan;
        logic [adc_width-1:0]  conv_data;
        sample_word_t          word;
        int                    delay;
        @(negedge clk);
        if (rst_n && adc_start_conv) begin
            exp_chan = next_enabled(model_mask, model_ptr);
            check(32'(adc_channel_sel), 32'(exp_chan), "channel order");
            model_ptr = exp_chan + 1'b1;
            if (fast_adc) begin
                delay = 1;
            end else begin
                delay = 1 + ($unsigned($random(seed)) % 20);
            end
            repeat (delay) @(posedge clk);
            conv_data     = adc_width'($random(seed));
            adc_conv_done <= 1'b1;
            adc_data      <= conv_data;
            word.spare = 1'b0;
            word.chan  = exp_chan;
            word.data  = conv_data;
            exp_q.push_back(word);
            @(posedge clk);
            adc_conv_done <= 1'b0;
        end
    end

    // Serial receiver, bits taken while valid is high
    always @(negedge clk) begin : serial_rx
        sample_word_t exp_word;
        if (rst_n && serial_valid) begin
            rx_shift = {rx_shift[14:0], serial_data};
            rx_bits++;
            if (rx_bits == 16) begin
                rx_bits = 0;
                if (exp_q.size() == 0) begin
                    abort_run("A serial word arrived with no conversion behind it");
                end else begin
                    exp_word = exp_q.pop_front();
                    check(32'(rx_shift), 32'(exp_word), "serial word");
                    rx_count++;
                end
            end
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin : main_seq
        logic [num_channels-1:0] new_mask;
        clk           = 1'b0;
        spi_sclk      = 1'b0;
        rst_n         = 1'b0;
        spi_cs_n      = 1'b1;
        spi_mosi      = 1'b0;
        adc_conv_done = 1'b0;
        adc_busy      = 1'b0;
        adc_data      = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Default settings scan all channels in order
        wait_rx(rx_batch);

        // Stop, change the mask, start again
        spi_write(reg_byte_addr(reg_ctrl_idx), 32'd0);
        wait_quiet();
        new_mask = num_channels'($random(seed));
        if (new_mask == '0) begin
            new_mask = 8'h01;
        end
        spi_write(reg_byte_addr(reg_chan_en_idx), 32'(new_mask));
        model_mask = new_mask;
        spi_write(reg_byte_addr(reg_ctrl_idx), 32'd1);
        wait_rx(rx_count + rx_batch);

        // Fast conversions outrun the serializer
        fast_adc = 1'b1;
        @(negedge clk);
        while (!i_dut.fifo_full) begin
            @(negedge clk);
        end
        repeat (200) @(posedge clk);
        spi_write(reg_byte_addr(reg_ctrl_idx), 32'd0);
        wait_quiet();
        // Drain until the DUT has nothing left to send
        while (serial_valid || !i_dut.fifo_empty) begin
            @(negedge clk);
        end
        check(32'(exp_q.size()), 32'd0, "words left in the expected queue");

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- daq_props.sv
`timescale 1ns/1ps

module daq_props (
    input logic clk,
    input logic rst_n,
    input logic reg_wr,
    input logic adc_start_conv,
    input logic sample_wr,
    input logic fifo_full,
    input logic serial_valid
);

    logic [4:0] valid_len;

    // Length of the current serial_valid run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_len <= '0;
        end else if (serial_valid) begin
            valid_len <= valid_len + 1'b1;
        end else begin
            valid_len <= '0;
        end
    end

    a_reg_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        reg_wr |=> !reg_wr)
        else $error("reg_wr longer than one cycle");

    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        adc_start_conv |=> !adc_start_conv)
        else $error("adc_start_conv longer than one cycle");

    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        sample_wr |-> !fifo_full)
        else $error("sample_wr while the FIFO is full");

    a_valid_max: assert property (@(posedge clk) disable iff (!rst_n)
        serial_valid |-> valid_len < 5'd16)
        else $error("serial_valid high for more than 16 cycles");

    a_valid_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(serial_valid) |-> valid_len == 5'd16)
        else $error("serial_valid high for fewer than 16 cycles");

endmodule

bind daq_top daq_props i_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .reg_wr         (reg_wr),
    .adc_start_conv (adc_start_conv),
    .sample_wr      (sample_wr),
    .fifo_full      (fifo_full),
    .serial_valid   (serial_valid)
);

//--- daq_top.sv
`timescale 1ns/1ps

module daq_top
    import daq_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  spi_sclk,
    input  logic                  spi_mosi,
    input  logic                  spi_cs_n,
    input  logic                  adc_conv_done,
    input  logic                  adc_busy,
    input  logic [adc_width-1:0]  adc_data,
    output logic                  adc_start_conv,
    output logic [chan_width-1:0] adc_channel_sel,
    output logic                  serial_data,
    output logic                  serial_valid
);

    logic                  reg_wr;
    reg_write_t            reg_wr_req;
    daq_cfg_t              cfg;
    logic                  chan_valid;
    logic [chan_width-1:0] chan_sel;
    logic                  chan_accept;
    logic                  sample_wr;
    sample_word_t          sample;
    sample_word_t          head_word;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  pop;

    // ====================
    // Host register path
    // ====================
    spi_reg_receiver u_spi (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi_sclk   (spi_sclk),
        .spi_cs_n   (spi_cs_n),
        .spi_mosi   (spi_mosi),
        .reg_wr     (reg_wr),
        .reg_wr_req (reg_wr_req)
    );

    daq_config_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_wr_req (reg_wr_req),
        .cfg        (cfg)
    );

    // ====================
    // Acquisition path
    // ====================
    channel_scanner u_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .chan_en_mask (cfg.chan_en),
        .chan_accept  (chan_accept),
        .chan_valid   (chan_valid),
        .chan_sel     (chan_sel)
    );

    adc_sequencer u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .chan_valid      (chan_valid),
        .chan_sel        (chan_sel),
        .adc_conv_done   (adc_conv_done),
        .adc_busy        (adc_busy),
        .adc_data        (adc_data),
        .fifo_full       (fifo_full),
        .adc_start_conv  (adc_start_conv),
        .adc_channel_sel (adc_channel_sel),
        .chan_accept     (chan_accept),
        .sample_wr       (sample_wr),
        .sample          (sample)
    );

    sample_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (sample_wr),
        .wr_word (sample),
        .pop     (pop),
        .rd_word (head_word),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    serial_framer u_ser (
        .clk          (clk),
        .rst_n        (rst_n),
        .empty        (fifo_empty),
        .rd_word      (head_word),
        .pop          (pop),
        .serial_data  (serial_data),
        .serial_valid (serial_valid)
    );

endmodule

//--- serial_framer.sv
`timescale 1ns/1ps

module serial_framer
    import daq_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         empty,
    input  sample_word_t rd_word,
    output logic         pop,
    output logic         serial_data,
    output logic         serial_valid
);

    logic [15:0] shift;
    logic [3:0]  bit_cnt;
    logic        busy;

    // Take the head word in the same cycle it is popped
    assign pop          = !busy && !empty;
    assign serial_data  = shift[15];
    assign serial_valid = busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (pop) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd15) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= rd_word;
        end else if (busy) begin
            shift <= {shift[14:0], 1'b0};
        end
    end

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
    import daq_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         wr,
    input  sample_word_t wr_word,
    input  logic         pop,
    output sample_word_t rd_word,
    output logic         full,
    output logic         empty
);

    sample_word_t               mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0]   count;
    logic                       do_wr;
    logic                       do_rd;

    assign full    = (count == (fifo_addr_width + 1)'(fifo_depth));
    assign empty   = (count == '0);
    assign do_wr   = wr && !full;
    assign do_rd   = pop && !empty;
    assign rd_word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_wr - do_rd;
        end
    end

endmodule

//--- adc_sequencer.sv
`timescale 1ns/1ps

module adc_sequencer
    import daq_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  daq_cfg_t              cfg,
    input  logic                  chan_valid,
    input  logic [chan_width-1:0] chan_sel,
    input  logic                  adc_conv_done,
    input  logic                  adc_busy,
    input  logic [adc_width-1:0]  adc_data,
    input  logic                  fifo_full,
    output logic                  adc_start_conv,
    output logic [chan_width-1:0] adc_channel_sel,
    output logic                  chan_accept,
    output logic                  sample_wr,
    output sample_word_t          sample
);

    typedef enum logic [2:0] {
        st_idle,
        st_settle,
        st_start,
        st_wait,
        st_capture,
        st_next
    } seq_state_t;

    typedef logic [$clog2(settle_cycles + 1)-1:0] settle_cnt_t;

    seq_state_t            state, next_state;
    settle_cnt_t           settle_cnt;
    logic [chan_width-1:0] chan_q;
    logic [adc_width-1:0]  data_q;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                // Full FIFO holds off the next channel
                if (chan_valid && cfg.enable && !adc_busy && !fifo_full) begin
                    next_state = st_settle;
                end
            end
            st_settle: begin
                if (settle_cnt == settle_cnt_t'(settle_cycles)) begin
                    next_state = st_start;
                end
            end
            st_start:   next_state = st_wait;
            st_wait: begin
                if (adc_conv_done) begin
                    next_state = st_capture;
                end
            end
            st_capture: next_state = st_next;
            default:    next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            settle_cnt <= '0;
            chan_q     <= '0;
        end else begin
            state      <= next_state;
            settle_cnt <= (state == st_settle) ? settle_cnt + 1'b1 : '0;
            if (state == st_idle && next_state == st_settle) begin
                chan_q <= chan_sel;
            end
        end
    end

    // Data is only valid alongside conv_done
    always_ff @(posedge clk) begin
        if (state == st_wait && adc_conv_done) begin
            data_q <= adc_data;
        end
    end

    assign adc_start_conv  = (state == st_start);
    assign adc_channel_sel = chan_q;
    assign sample_wr       = (state == st_capture);
    assign chan_accept     = (state == st_capture);
    assign sample.spare    = 1'b0;
    assign sample.chan     = chan_q;
    assign sample.data     = data_q;

endmodule

//--- channel_scanner.sv
`timescale 1ns/1ps

module channel_scanner
    import daq_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [num_channels-1:0] chan_en_mask,
    input  logic                    chan_accept,
    output logic                    chan_valid,
    output logic [chan_width-1:0]   chan_sel
);

    logic [chan_width-1:0] ptr;
    logic [chan_width-1:0] cand;

    // Circular search from ptr, lowest offset wins
    always_comb begin
        chan_valid = 1'b0;
        chan_sel   = ptr;
        cand       = ptr;
        for (int i = num_channels - 1; i >= 0; i--) begin
            cand = ptr + chan_width'(i);
            if (chan_en_mask[cand]) begin
                chan_valid = 1'b1;
                chan_sel   = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (chan_accept) begin
            ptr <= chan_sel + 1'b1;
        end
    end

endmodule

//--- daq_config_regs.sv
`timescale 1ns/1ps

module daq_config_regs
    import daq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reg_wr,
    input  reg_write_t reg_wr_req,
    output daq_cfg_t   cfg
);

    logic [4:0] reg_idx;

    // Word index from the byte address
    assign reg_idx = reg_wr_req.addr[6:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.enable  <= ctrl_default;
            cfg.chan_en <= chan_en_default;
        end else if (reg_wr) begin
            case (reg_idx)
                reg_ctrl_idx: begin
                    cfg.enable <= reg_wr_req.data[0];
                end
                reg_chan_en_idx: begin
                    cfg.chan_en <= reg_wr_req.data[num_channels-1:0];
                end
                default: ;
            endcase
        end
    end

endmodule

//--- spi_reg_receiver.sv
`timescale 1ns/1ps

module spi_reg_receiver
    import daq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    output logic       reg_wr,
    output reg_write_t reg_wr_req
);

    typedef enum logic [2:0] {
        fr_cmd,
        fr_addr_hi,
        fr_addr_lo,
        fr_data0,
        fr_data1,
        fr_data2,
        fr_data3,
        fr_done
    } frame_state_t;

    // SPI clock domain
    frame_state_t        frame_state;
    logic [2:0]          bit_cnt;
    logic [6:0]          shift;
    logic [7:0]          byte_in;
    logic                byte_done;
    logic [15:0]         addr_spi;
    logic [31:0]         data_spi;
    logic                frame_done;
    logic                cs_meta, cs_sync, cs_sync_q;
    logic                cs_rise;
    logic                ack_meta, ack_sync;
    logic                req_spi;

    // System clock domain
    logic                req_meta, req_sync, req_sync_q;
    logic                req_rise;
    logic                ack_pulse;
    logic                ack_hold;

    assign byte_in   = {shift, spi_mosi};
    assign byte_done = !spi_cs_n && (bit_cnt == 3'd7);
    assign cs_rise   = cs_sync && !cs_sync_q;

    // ====================
    // Frame capture
    // ====================
    always_ff @(posedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            frame_state <= fr_cmd;
        end else if (spi_cs_n) begin
            bit_cnt     <= '0;
            frame_state <= fr_cmd;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            // Extra bits after the last data byte are ignored
            if (byte_done && frame_state != fr_done) begin
                frame_state <= frame_state_t'(frame_state + 1'b1);
            end
        end
    end

    always_ff @(posedge spi_sclk) begin
        if (!spi_cs_n) begin
            shift <= byte_in[6:0];
        end
        if (byte_done) begin
            case (frame_state)
                fr_addr_hi: addr_spi[15:8]  <= byte_in;
                fr_addr_lo: addr_spi[7:0]   <= byte_in;
                fr_data0:   data_spi[31:24] <= byte_in;
                fr_data1:   data_spi[23:16] <= byte_in;
                fr_data2:   data_spi[15:8]  <= byte_in;
                fr_data3:   data_spi[7:0]   <= byte_in;
                default:    ;
            endcase
        end
    end

    // Complete frame waits here for CS to go high
    always_ff @(posedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else if (cs_rise) begin
            frame_done <= 1'b0;
        end else if (byte_done && frame_state == fr_data3) begin
            frame_done <= 1'b1;
        end
    end

    // ====================
    // Request side
    // ====================
    always_ff @(posedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            cs_meta   <= 1'b1;
            cs_sync   <= 1'b1;
            cs_sync_q <= 1'b1;
            ack_meta  <= 1'b0;
            ack_sync  <= 1'b0;
            req_spi   <= 1'b0;
        end else begin
            cs_meta   <= spi_cs_n;
            cs_sync   <= cs_meta;
            cs_sync_q <= cs_sync;
            ack_meta  <= ack_hold;
            ack_sync  <= ack_meta;
            // Hold the request until the acknowledge comes back
            if (ack_sync) begin
                req_spi <= 1'b0;
            end else if (cs_rise && frame_done) begin
                req_spi <= 1'b1;
            end
        end
    end

    // ====================
    // Write strobe side
    // ====================
    assign req_rise = req_sync && !req_sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_meta   <= 1'b0;
            req_sync   <= 1'b0;
            req_sync_q <= 1'b0;
            reg_wr     <= 1'b0;
            ack_pulse  <= 1'b0;
            ack_hold   <= 1'b0;
        end else begin
            req_meta   <= req_spi;
            req_sync   <= req_meta;
            req_sync_q <= req_sync;
            reg_wr     <= req_rise;
            ack_pulse  <= reg_wr;
            // Stretch the ack until the request is seen low
            if (ack_pulse) begin
                ack_hold <= 1'b1;
            end else if (!req_sync) begin
                ack_hold <= 1'b0;
            end
        end
    end

    // Address and data are stable while the request is up
    always_ff @(posedge clk) begin
        if (req_rise) begin
            reg_wr_req.addr <= addr_spi;
            reg_wr_req.data <= data_spi;
        end
    end

endmodule

//--- daq_pkg.sv
package daq_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int num_channels    = 8;
    localparam int chan_width      = $clog2(num_channels);
    localparam int adc_width       = 12;
    localparam int fifo_depth      = 16;
    localparam int fifo_addr_width = $clog2(fifo_depth);
    localparam int settle_cycles   = 8;

    localparam int reg_addr_width  = 16;
    localparam int reg_data_width  = 32;

    // ====================
    // Register map
    // ====================
    // Index is byte address bits 6:2
    localparam logic [4:0] reg_ctrl_idx    = 5'd0;
    localparam logic [4:0] reg_chan_en_idx = 5'd1;

    localparam logic                    ctrl_default    = 1'b1;
    localparam logic [num_channels-1:0] chan_en_default = {num_channels{1'b1}};

    // ====================
    // Shared types
    // ====================
    typedef struct packed {
        logic [reg_addr_width-1:0] addr;
        logic [reg_data_width-1:0] data;
    } reg_write_t;

    typedef struct packed {
        logic                  spare;
        logic [chan_width-1:0] chan;
        logic [adc_width-1:0]  data;
    } sample_word_t;

    typedef struct packed {
        logic                    enable;
        logic [num_channels-1:0] chan_en;
    } daq_cfg_t;

endpackage
